//--- list.f
+incdir+hdl
hdl/ingress_pkg.sv
hdl/ingress_port_buffer.sv
hdl/ingress_arbiter.sv
hdl/p4_router_ingress.sv
testbench/p4_router_ingress_tb.sv

//--- run.sh
#!/bin/sh
# Compile the router ingress testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on the PATH"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f list.f \
    --top-module p4_router_ingress_tb -o sim_p4_router_ingress
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_p4_router_ingress 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

//--- testbench/p4_router_ingress_tb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the router ingress stage, drives all ports
// and checks bus beats, port tags, packet order and counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ingress_config.svh"

module p4_router_ingress_tb;

    import ingress_pkg::*;

    localparam int NUM_PORTS    = `ING_NUM_PORTS;
    localparam int DATA_BYTES   = `ING_DATA_BYTES;
    localparam int DEPTH        = `ING_BUF_DEPTH_WORDS;
    localparam int MTU          = `ING_MTU_BYTES;
    localparam int CLK_PERIOD   = 4;
    localparam int SEED         = 6;
    localparam int MIN_BYTES    = 8;
    localparam int PKTS_ROUND   = 3;
    localparam int PKTS_FLOOD   = 6;
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;
    // Five normal rounds plus the flood, per port
    localparam int TOTAL_PKTS   = NUM_PORTS * (5 * PKTS_ROUND + PKTS_FLOOD);
    // Four cycles per MTU byte of every packet, doubled for drains
    localparam longint WATCHDOG_NS = longint'(TOTAL_PKTS) * MTU * 4 * CLK_PERIOD * 2;
    localparam logic [NUM_PORTS-1:0] ONE_PORT_OFF = ~NUM_PORTS'(2);

    logic                 core_clk_ifc;
    logic                 packet_sink_reset;
    logic [NUM_PORTS-1:0] phys_valid;
    ing_word_t            phys_words [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_phys_ports_enable;
    logic [NUM_PORTS-1:0] ing_cnts_clear;
    port_cnt_t            ing_cnts [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_buf_overflow;
    logic                 ing_bus_valid;
    ing_beat_t            ing_bus;
    logic                 ing_bus_ready;
    logic                 ing_bus_pkt_cnt_clear;
    bus_cnt_t             ing_bus_pkt_cnt;

    // Reference model
    ing_word_t            exp_q [NUM_PORTS][$];
    ing_word_t            tx_q [NUM_PORTS][$];
    int                   exp_port_cnt [NUM_PORTS];
    int                   exp_bus_cnt;
    logic [NUM_PORTS-1:0] ovf_seen;
    logic                 discard;
    int                   ready_mode;

    p4_router_ingress i_dut (
        .core_clk_ifc          (core_clk_ifc),
        .packet_sink_reset     (packet_sink_reset),
        .phys_valid            (phys_valid),
        .phys_words            (phys_words),
        .ing_phys_ports_enable (ing_phys_ports_enable),
        .ing_cnts_clear        (ing_cnts_clear),
        .ing_cnts              (ing_cnts),
        .ing_buf_overflow      (ing_buf_overflow),
        .ing_bus_valid         (ing_bus_valid),
        .ing_bus               (ing_bus),
        .ing_bus_ready         (ing_bus_ready),
        .ing_bus_pkt_cnt_clear (ing_bus_pkt_cnt_clear),
        .ing_bus_pkt_cnt       (ing_bus_pkt_cnt)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the tests finished", $time);
        $display("test failed");
        $fatal(1, "run aborted by watchdog");
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting and compare tasks

    task automatic report_value_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_beat(input ing_beat_t got, input ing_beat_t exp);
        if (got !== exp) begin
            report_value_error($sformatf("bus beat %h from port %0d, expected %h",
                                         got, got.meta.ingress_port, exp));
        end
    endtask

    task automatic verify_port_cnt(input int port, input port_cnt_t got, input port_cnt_t exp);
        if (got !== exp) begin
            report_value_error($sformatf("port %0d packet count %0d, expected %0d",
                                         port, got, exp));
        end
    endtask

    task automatic expect_bus_cnt(input bus_cnt_t got, input bus_cnt_t exp);
        if (got !== exp) begin
            report_value_error($sformatf("bus packet count %0d, expected %0d", got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus ready pattern and receiver

    initial begin
        ing_bus_ready = 1'b1;
        forever begin
            @(posedge core_clk_ifc);
            case (ready_mode)
                READY_LOW:    ing_bus_ready <= 1'b0;
                READY_RANDOM: ing_bus_ready <= 1'($urandom_range(1, 0));
                default:      ing_bus_ready <= 1'b1;
            endcase
        end
    end

    // Port whose next pending packet starts with this word, or -1
    function automatic int match_port(input ing_word_t w);
        int found;
        found = -1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (found < 0 && exp_q[p].size() != 0 && exp_q[p][0] === w) begin
                found = p;
            end
        end
        return found;
    endfunction

    // Outputs are sampled just before each rising edge
    initial begin
        ing_beat_t prev_beat;
        ing_beat_t exp_beat;
        logic      stalled;
        logic      in_pkt;
        port_id_t  cur_port;
        int        p;
        ovf_seen = '0;
        stalled  = 1'b0;
        in_pkt   = 1'b0;
        cur_port = '0;
        forever begin
            @(posedge core_clk_ifc);
            if (ing_buf_overflow != '0) begin
                if (!discard) begin
                    abort_run($sformatf("Unexpected overflow on ports %b", ing_buf_overflow));
                end
                ovf_seen = ovf_seen | ing_buf_overflow;
            end
            if (stalled && (!ing_bus_valid || ing_bus !== prev_beat)) begin
                report_value_error("bus beat changed while ready was low");
            end
            stalled   = ing_bus_valid && !ing_bus_ready;
            prev_beat = ing_bus;
            if (ing_bus_valid && ing_bus_ready) begin
                if (!discard) begin
                    // A new packet is traced back to its port by its first word
                    if (!in_pkt) begin
                        p = match_port(ing_bus.word);
                        if (p < 0) begin
                            abort_run($sformatf("Beat %h matches no packet sent", ing_bus));
                        end
                        cur_port = port_id_t'(p);
                    end
                    exp_beat.word              = exp_q[cur_port].pop_front();
                    exp_beat.meta.ingress_port = cur_port;
                    compare_beat(ing_bus, exp_beat);
                end
                in_pkt = !ing_bus.word.last;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    // Random payload, keep is partial only on the last word
    task automatic build_packet(input int p, input int len, input logic expect_out);
        ing_word_t w;
        int        nwords;
        int        nbytes;
        nwords = (len + DATA_BYTES - 1) / DATA_BYTES;
        for (int i = 0; i < nwords; i++) begin
            nbytes = (i == nwords - 1) ? len - i * DATA_BYTES : DATA_BYTES;
            w.data = $urandom();
            w.keep = '0;
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (b < nbytes) begin
                    w.keep[b] = 1'b1;
                end else begin
                    w.data[b*8 +: 8] = 8'h00;
                end
            end
            w.last = (i == nwords - 1);
            tx_q[p].push_back(w);
            if (expect_out && ing_phys_ports_enable[p]) begin
                exp_q[p].push_back(w);
            end
        end
        if (ing_phys_ports_enable[p]) begin
            exp_port_cnt[p]++;
            if (expect_out) begin
                exp_bus_cnt++;
            end
        end
    endtask

    // All ports send at once; kept traffic waits until it fits the buffer
    task automatic run_traffic(input int pkts, input int min_bytes, input logic expect_out);
        int   left [NUM_PORTS];
        int   next_len [NUM_PORTS];
        int   nwords;
        logic busy;
        for (int p = 0; p < NUM_PORTS; p++) begin
            left[p]     = pkts;
            next_len[p] = $urandom_range(MTU, min_bytes);
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge core_clk_ifc);
            busy = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                nwords = (next_len[p] + DATA_BYTES - 1) / DATA_BYTES;
                if (tx_q[p].size() == 0 && left[p] > 0 &&
                    (!expect_out || exp_q[p].size() + nwords <= DEPTH)) begin
                    build_packet(p, next_len[p], expect_out);
                    next_len[p] = $urandom_range(MTU, min_bytes);
                    left[p]--;
                end
                if (tx_q[p].size() > 0) begin
                    phys_valid[p] <= 1'b1;
                    phys_words[p] <= tx_q[p].pop_front();
                    busy = 1'b1;
                end else begin
                    phys_valid[p] <= 1'b0;
                end
                if (left[p] > 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic pulse_clears();
        @(posedge core_clk_ifc);
        ing_cnts_clear        <= '1;
        ing_bus_pkt_cnt_clear <= 1'b1;
        @(posedge core_clk_ifc);
        ing_cnts_clear        <= '0;
        ing_bus_pkt_cnt_clear <= 1'b0;
        @(posedge core_clk_ifc);
    endtask

    task automatic wait_bus_idle();
        int quiet;
        quiet = 0;
        while (quiet < MTU) begin
            @(posedge core_clk_ifc);
            quiet = ing_bus_valid ? 0 : quiet + 1;
        end
    endtask

    task automatic start_round(input logic [NUM_PORTS-1:0] enables, input int mode);
        @(posedge core_clk_ifc);
        ing_phys_ports_enable <= enables;
        ready_mode = mode;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_port_cnt[p] = 0;
        end
        exp_bus_cnt = 0;
        pulse_clears();
    endtask

    task automatic finish_round();
        wait_bus_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                abort_run($sformatf("Port %0d has %0d words that never left the bus",
                                    p, exp_q[p].size()));
            end
            verify_port_cnt(p, ing_cnts[p], port_cnt_t'(exp_port_cnt[p]));
        end
        expect_bus_cnt(ing_bus_pkt_cnt, bus_cnt_t'(exp_bus_cnt));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic confirm_reset_state();
        if (ing_bus_valid !== 1'b0 || ing_buf_overflow !== '0) begin
            abort_run("Bus valid or overflow is not low after reset");
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            verify_port_cnt(p, ing_cnts[p], '0);
        end
        expect_bus_cnt(ing_bus_pkt_cnt, '0);
    endtask

    task automatic send_on_all_ports(input int mode);
        start_round('1, mode);
        run_traffic(PKTS_ROUND, MIN_BYTES, 1'b1);
        finish_round();
    endtask

    task automatic keep_all_ports_off();
        start_round('0, READY_HIGH);
        run_traffic(PKTS_ROUND, MIN_BYTES, 1'b1);
        finish_round();
    endtask

    task automatic drop_one_port();
        start_round(ONE_PORT_OFF, READY_HIGH);
        run_traffic(PKTS_ROUND, MIN_BYTES, 1'b1);
        finish_round();
    endtask

    task automatic flood_and_recover();
        start_round('1, READY_LOW);
        discard = 1'b1;
        run_traffic(PKTS_FLOOD, MTU / 2, 1'b0);
        // Overflow pulses trail the rejected word by a cycle
        repeat (4) @(posedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!ovf_seen[p]) begin
                abort_run($sformatf("No overflow pulse seen on port %0d", p));
            end
            verify_port_cnt(p, ing_cnts[p], port_cnt_t'(exp_port_cnt[p]));
        end
        ready_mode = READY_HIGH;
        wait_bus_idle();
        discard = 1'b0;
        pulse_clears();
        for (int p = 0; p < NUM_PORTS; p++) begin
            verify_port_cnt(p, ing_cnts[p], '0);
        end
        expect_bus_cnt(ing_bus_pkt_cnt, '0);
        send_on_all_ports(READY_HIGH);
    endtask

    initial begin
        void'($urandom(SEED));
        packet_sink_reset     = 1'b1;
        phys_valid            = '0;
        ing_phys_ports_enable = '0;
        ing_cnts_clear        = '0;
        ing_bus_pkt_cnt_clear = 1'b0;
        discard               = 1'b0;
        ready_mode            = READY_HIGH;
        for (int p = 0; p < NUM_PORTS; p++) begin
            phys_words[p] = '0;
        end
        repeat (2) @(posedge core_clk_ifc);
        packet_sink_reset <= 1'b0;
        @(posedge core_clk_ifc);
        confirm_reset_state();
        send_on_all_ports(READY_HIGH);
        keep_all_ports_off();
        drop_one_port();
        send_on_all_ports(READY_RANDOM);
        flood_and_recover();
        $display("test passed");
        $finish;
    end

endmodule

//--- hdl/p4_router_ingress.sv
//////////////////////////////////////////////////////////////////////
// Router ingress top: one packet buffer per physical port feeding a
// round-robin arbiter onto the ingress bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ingress_config.svh"

module p4_router_ingress (
    input  logic                      core_clk_ifc,
    input  logic                      packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0] phys_valid,
    input  ingress_pkg::ing_word_t    phys_words [`ING_NUM_PORTS],
    input  logic [`ING_NUM_PORTS-1:0] ing_phys_ports_enable,
    input  logic [`ING_NUM_PORTS-1:0] ing_cnts_clear,
    output ingress_pkg::port_cnt_t    ing_cnts [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0] ing_buf_overflow,
    output logic                      ing_bus_valid,
    output ingress_pkg::ing_beat_t    ing_bus,
    input  logic                      ing_bus_ready,
    input  logic                      ing_bus_pkt_cnt_clear,
    output ingress_pkg::bus_cnt_t     ing_bus_pkt_cnt
);

    import ingress_pkg::*;

    logic [`ING_NUM_PORTS-1:0] pkt_ready;
    logic [`ING_NUM_PORTS-1:0] pop;
    ing_word_t                 head_words [`ING_NUM_PORTS];

    // One buffer per physical port
    for (genvar i = 0; i < `ING_NUM_PORTS; i++) begin : g_port
        ingress_port_buffer i_buffer (
            .clk               (core_clk_ifc),
            .packet_sink_reset (packet_sink_reset),
            .port_enable       (ing_phys_ports_enable[i]),
            .phys_valid        (phys_valid[i]),
            .phys_word         (phys_words[i]),
            .cnt_clear         (ing_cnts_clear[i]),
            .pkt_cnt           (ing_cnts[i]),
            .overflow          (ing_buf_overflow[i]),
            .pkt_ready         (pkt_ready[i]),
            .head_word         (head_words[i]),
            .pop               (pop[i])
        );
    end

    ingress_arbiter i_arbiter (
        .clk               (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .pkt_ready         (pkt_ready),
        .head_words        (head_words),
        .pop               (pop),
        .ing_bus_valid     (ing_bus_valid),
        .ing_bus           (ing_bus),
        .ing_bus_ready     (ing_bus_ready),
        .bus_cnt_clear     (ing_bus_pkt_cnt_clear),
        .bus_pkt_cnt       (ing_bus_pkt_cnt)
    );

endmodule

//--- hdl/ingress_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Round-robin merge of whole packets from the port buffers onto the
// ingress bus, with port tagging and a packet counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ingress_config.svh"

module ingress_arbiter (
    input  logic                   clk,
    input  logic                   packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0] pkt_ready,
    input  ingress_pkg::ing_word_t head_words [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0] pop,
    output logic                   ing_bus_valid,
    output ingress_pkg::ing_beat_t ing_bus,
    input  logic                   ing_bus_ready,
    input  logic                   bus_cnt_clear,
    output ingress_pkg::bus_cnt_t  bus_pkt_cnt
);

    import ingress_pkg::*;

    localparam int NUM_PORTS = `ING_NUM_PORTS;

    logic     busy;
    logic     tail_popped;
    port_id_t grant;
    port_id_t last_grant;

    logic     next_found;
    port_id_t next_port;

    logic     take;
    logic     bus_xfer;

    //////////////////////////////////////////////////////////////////////
    // Port selection

    // First ready port after the one granted last
    always_comb begin
        int idx;
        next_found = 1'b0;
        next_port  = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            idx = (int'(last_grant) + 1 + k) % NUM_PORTS;
            if (!next_found && pkt_ready[idx]) begin
                next_found = 1'b1;
                next_port  = port_id_t'(idx);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Packet streaming

    // Take a word when the output register is free or draining
    assign take     = busy && !tail_popped && (!ing_bus_valid || ing_bus_ready);
    assign bus_xfer = ing_bus_valid && ing_bus_ready;

    always_comb begin
        pop        = '0;
        pop[grant] = take;
    end

    always_ff @(posedge clk) begin
        if (packet_sink_reset) begin
            busy          <= 1'b0;
            tail_popped   <= 1'b0;
            grant         <= '0;
            last_grant    <= port_id_t'(NUM_PORTS - 1);
            ing_bus_valid <= 1'b0;
        end else begin
            if (!busy) begin
                if (next_found) begin
                    busy       <= 1'b1;
                    grant      <= next_port;
                    last_grant <= next_port;
                end
            end else if (bus_xfer && ing_bus.word.last) begin
                // Whole packet is out, free the grant
                busy        <= 1'b0;
                tail_popped <= 1'b0;
            end else if (take && head_words[grant].last) begin
                tail_popped <= 1'b1;
            end

            if (take) begin
                ing_bus_valid <= 1'b1;
            end else if (bus_xfer) begin
                ing_bus_valid <= 1'b0;
            end
        end
    end

    // Beat payload, tagged with the granted port
    always_ff @(posedge clk) begin
        if (take) begin
            ing_bus.word              <= head_words[grant];
            ing_bus.meta.ingress_port <= grant;
        end
    end

    always_ff @(posedge clk) begin
        if (packet_sink_reset || bus_cnt_clear) begin
            bus_pkt_cnt <= '0;
        end else if (bus_xfer && ing_bus.word.last) begin
            bus_pkt_cnt <= bus_pkt_cnt + 1'b1;
        end
    end

endmodule

//--- hdl/ingress_port_buffer.sv
//////////////////////////////////////////////////////////////////////
// Per-port packet buffer: enable gate, packet counter and a word FIFO
// that drops whole packets on overflow and releases only full ones
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "ingress_config.svh"

module ingress_port_buffer (
    input  logic                  clk,
    input  logic                  packet_sink_reset,
    input  logic                  port_enable,
    input  logic                  phys_valid,
    input  ingress_pkg::ing_word_t phys_word,
    input  logic                  cnt_clear,
    output ingress_pkg::port_cnt_t pkt_cnt,
    output logic                  overflow,
    output logic                  pkt_ready,
    output ingress_pkg::ing_word_t head_word,
    input  logic                  pop
);

    import ingress_pkg::*;

    localparam int DEPTH = `ING_BUF_DEPTH_WORDS;
    localparam int AW    = $clog2(DEPTH);
    // One extra bit tells full from empty
    localparam int PW    = AW + 1;

    ing_word_t mem [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] pkt_start;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] pkt_avail;

    logic in_pkt;
    logic pkt_en_q;
    logic dropping;
    logic commit_q;

    logic word_en;
    logic wr_accept;
    logic buf_full;
    logic pop_last;

    //////////////////////////////////////////////////////////////////////
    // Input side

    // Enable is sampled on the first word and held to the end of the packet
    assign word_en   = in_pkt ? pkt_en_q : port_enable;
    assign wr_accept = phys_valid && word_en && !dropping;

    // Tentative words count against the space too
    assign buf_full  = (wr_ptr - rd_ptr) == PW'(DEPTH);

    always_ff @(posedge clk) begin
        if (packet_sink_reset) begin
            in_pkt    <= 1'b0;
            pkt_en_q  <= 1'b0;
            dropping  <= 1'b0;
            wr_ptr    <= '0;
            pkt_start <= '0;
            commit_q  <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            commit_q <= 1'b0;
            overflow <= 1'b0;

            if (phys_valid) begin
                in_pkt <= !phys_word.last;
                if (!in_pkt) begin
                    pkt_en_q <= port_enable;
                end
            end

            if (wr_accept) begin
                if (buf_full) begin
                    // No room, throw away what was written of this packet
                    wr_ptr   <= pkt_start;
                    overflow <= 1'b1;
                    dropping <= !phys_word.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (phys_word.last) begin
                        pkt_start <= wr_ptr + 1'b1;
                        commit_q  <= 1'b1;
                    end
                end
            end else if (phys_valid && phys_word.last) begin
                // End of a discarded packet
                dropping <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept && !buf_full) begin
            mem[wr_ptr[AW-1:0]] <= phys_word;
        end
    end

    // Counts every enabled packet seen at the port, kept or not
    always_ff @(posedge clk) begin
        if (packet_sink_reset || cnt_clear) begin
            pkt_cnt <= '0;
        end else if (phys_valid && word_en && phys_word.last) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output side

    assign head_word = mem[rd_ptr[AW-1:0]];
    assign pop_last  = pop && head_word.last;
    assign pkt_ready = pkt_avail != '0;

    always_ff @(posedge clk) begin
        if (packet_sink_reset) begin
            rd_ptr    <= '0;
            pkt_avail <= '0;
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Committed packets waiting for the arbiter
            case ({commit_q, pop_last})
                2'b10:   pkt_avail <= pkt_avail + 1'b1;
                2'b01:   pkt_avail <= pkt_avail - 1'b1;
                default: pkt_avail <= pkt_avail;
            endcase
        end
    end

endmodule

//--- hdl/ingress_pkg.sv
//////////////////////////////////////////////////////////////////////
// Word, beat and counter types for the ingress ports and the
// merged ingress bus
//////////////////////////////////////////////////////////////////////

`include "ingress_config.svh"

package ingress_pkg;

    // Ingress port number
    typedef logic [$clog2(`ING_NUM_PORTS)-1:0] port_id_t;

    // One port word, keep is contiguous from byte 0
    typedef struct packed {
        logic [`ING_DATA_BYTES*8-1:0] data;
        logic [`ING_DATA_BYTES-1:0]   keep;
        logic                         last;
    } ing_word_t;

    // Side-band information carried with every bus beat
    typedef struct packed {
        port_id_t ingress_port;
    } ing_metadata_t;

    // One beat on the ingress bus
    typedef struct packed {
        ing_word_t     word;
        ing_metadata_t meta;
    } ing_beat_t;

    typedef logic [`ING_PORT_CNT_WIDTH-1:0] port_cnt_t;
    typedef logic [`ING_BUS_CNT_WIDTH-1:0]  bus_cnt_t;

endpackage

//--- hdl/ingress_config.svh
//////////////////////////////////////////////////////////////////////
// Build-time sizing of the router ingress stage, shared by the
// package, the RTL and the testbench
//////////////////////////////////////////////////////////////////////

`ifndef INGRESS_CONFIG_SVH
`define INGRESS_CONFIG_SVH

// Number of physical ingress ports
`define ING_NUM_PORTS 4

// Bytes per port word and per ingress bus beat
`define ING_DATA_BYTES 4

// Words held by each port buffer, power of two
`define ING_BUF_DEPTH_WORDS 128

// Largest packet in bytes
`define ING_MTU_BYTES 256

// Counter widths
`define ING_PORT_CNT_WIDTH 32
`define ING_BUS_CNT_WIDTH 64

`endif
